// File: build.f
+incdir+.
decode_pkg.sv
id_decoder.sv
id_stage.sv
regfile.sv
csr_file.sv
inst_counter.sv
decode_top.sv
tb_decode_top.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the decode subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
    -f build.f --top-module tb_decode_top; then
  echo "Verilator build failed."
  exit 1
fi

if ! ./obj_dir/Vtb_decode_top > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status."
  exit 1
fi

cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation failed."
  exit 1
fi

// File: tb_decode_top.sv
////////////////////////////////////////////////////////////////////////////
// Decode subsystem testbench: instruction table through both handshakes.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "decode_macros.svh"

module tb_decode_top;

  timeunit 1ns;
  timeprecision 100ps;

  import decode_pkg::*;

  localparam int TIMEOUT = 50;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_IMM    = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  logic      clk = 1'b0;
  logic      rst;
  logic      i_fetched_req, o_fetched_ack, o_decoded_req, i_decoded_ack;
  xlen_t     i_pc, i_pc_pred, o_pc, o_pc_pred;
  inst_t     i_inst, o_inst;
  reg_addr_t o_rs1, o_rs2, o_rd, i_wb_rd;
  logic      o_rs1_ren, o_rs2_ren, o_memren, o_memwen, i_wb_en, i_csr_wen;
  itype_e    o_itype;
  logic [6:0] o_opcode;
  logic [2:0] o_funct3;
  logic [6:0] o_funct7;
  xlen_t     o_op1, o_op2, o_t1, o_memaddr, o_memwdata, o_csr_wdata;
  csr_addr_t o_csr_addr, i_csr_waddr;
  csr_op_e   o_csr_op;
  xlen_t     i_wb_data, i_csr_wdata;

  // stimulus table and testbench models.
  inst_t       row_inst [$];
  xlen_t       row_pc [$];
  xlen_t       row_imm [$];
  int          row_hold [$];
  xlen_t       model_regs [`NUM_REGS];
  xlen_t       model_mscratch;
  xlen_t       last_mcycle;
  xlen_t       cycle_count;
  logic [31:0] lfsr_state;

  itype_e  exp_itype;
  csr_op_e exp_csr_op;
  logic    exp_rs1_ren, exp_rs2_ren, exp_memren, exp_memwen;
  xlen_t   exp_op1, exp_op2, exp_t1, exp_memaddr, exp_memwdata, exp_csr_wdata;

  decode_top DUT (.*);

  always #4 clk = ~clk;

  // mcycle model counts every edge after reset.
  always @(posedge clk) begin
    if (rst) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 64'd1;
    end
  end

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic xlen_t random_word();
    xlen_t w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[62:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic inst_t r_form(input logic [6:0] f7, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t i_form(input longint imm, input reg_addr_t rs1,
      input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic inst_t s_form(input longint imm, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic inst_t b_form(input longint imm, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3, input logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction

  function automatic inst_t u_form(input longint imm, input reg_addr_t rd,
      input logic [6:0] opc);
    return {imm[31:12], rd, opc};
  endfunction

  function automatic inst_t j_form(input longint imm, input reg_addr_t rd,
      input logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

  task automatic add_row(input inst_t inst, input xlen_t pc, input longint imm,
      input int hold);
    row_inst.push_back(inst);
    row_pc.push_back(pc);
    row_imm.push_back(xlen_t'(imm));
    row_hold.push_back(hold);
  endtask

  task automatic build_table();
    add_row(r_form(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), 64'h1000, 0, 0);
    add_row(r_form(7'h00, 5'd7, 5'd6, 3'd0, 5'd5, OPC_OP), 64'h1004, 0, 3);
    add_row(r_form(7'h20, 5'd9, 5'd0, 3'd0, 5'd8, OPC_OP), 64'h1008, 0, 0);
    add_row(i_form(-5, 5'd11, 3'd0, 5'd10, OPC_IMM), 64'h100c, -5, 0);
    add_row(i_form('h123, 5'd13, 3'd3, 5'd12, OPC_LOAD), 64'h1010, 'h123, 2);
    add_row(s_form(-16, 5'd14, 5'd15, 3'd3, OPC_STORE), 64'h1014, -16, 0);
    add_row(b_form(-32, 5'd17, 5'd16, 3'd0, OPC_BRANCH), 64'h2000, -32, 1);
    add_row(u_form(64'shFFFF_FFFF_8000_0000, 5'd18, OPC_LUI), 64'h2004,
            64'shFFFF_FFFF_8000_0000, 0);
    add_row(u_form('h12345000, 5'd19, OPC_AUIPC), 64'h3000, 'h12345000, 0);
    add_row(j_form(-2048, 5'd1, OPC_JAL), 64'h4000, -2048, 1);
    add_row(i_form('h55, 5'd20, 3'd0, 5'd1, OPC_JALR), 64'h4004, 'h55, 0);
    // csrrw, csrrs, csrrc, csrrsi, then an unknown address.
    add_row(i_form(`CSR_MSCRATCH, 5'd22, 3'd1, 5'd21, OPC_SYSTEM), 64'h5000, 0, 0);
    add_row(i_form(`CSR_MSCRATCH, 5'd23, 3'd2, 5'd0, OPC_SYSTEM), 64'h5004, 0, 2);
    add_row(i_form(`CSR_MSCRATCH, 5'd25, 3'd3, 5'd24, OPC_SYSTEM), 64'h5008, 0, 0);
    add_row(i_form(`CSR_MSCRATCH, 5'd13, 3'd6, 5'd26, OPC_SYSTEM), 64'h500c, 0, 0);
    add_row(i_form('h7c0, 5'd0, 3'd2, 5'd27, OPC_SYSTEM), 64'h5010, 0, 0);
    // minstret read, then two mcycle reads.
    add_row(i_form(`CSR_MINSTRET, 5'd0, 3'd2, 5'd28, OPC_SYSTEM), 64'h5014, 0, 0);
    add_row(i_form(`CSR_MCYCLE, 5'd0, 3'd2, 5'd29, OPC_SYSTEM), 64'h5018, 0, 0);
    add_row(i_form(`CSR_MCYCLE, 5'd0, 3'd2, 5'd30, OPC_SYSTEM), 64'h501c, 0, 0);
    add_row(32'h1234_567f, 64'h6000, 0, 2);
  endtask

  task automatic word_eq(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic index_eq(input string name, input reg_addr_t got,
      input reg_addr_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic itype_eq(input string name, input itype_e got, input itype_e exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
               exp.name());
      $display("ERRORS FOUND");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic csr_op_eq(input string name, input csr_op_e got, input csr_op_e exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
               exp.name());
      $display("ERRORS FOUND");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic bit_eq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic wait_fetch_ack();
    int n;
    n = 0;
    @(negedge clk);
    while (!o_fetched_ack) begin
      n++;
      if (n > TIMEOUT) begin
        $display("The wait for o_fetched_ack to accept an instruction timed out.");
        $display("ERRORS FOUND");
        $fatal(1, "handshake timeout");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_decode_req();
    int n;
    n = 0;
    @(negedge clk);
    while (!o_decoded_req) begin
      n++;
      if (n > TIMEOUT) begin
        $display("The wait for o_decoded_req after a fetch transfer timed out.");
        $display("ERRORS FOUND");
        $fatal(1, "handshake timeout");
      end
      @(negedge clk);
    end
  endtask

  // expected decode of a row from the ISA rules and the models.
  task automatic predict_row(input int idx);
    inst_t inst;
    xlen_t a;
    xlen_t b;
    xlen_t imm;
    xlen_t pc;
    xlen_t src;
    xlen_t sum;
    inst = row_inst[idx];
    imm  = row_imm[idx];
    pc   = row_pc[idx];
    a    = model_regs[inst[19:15]];
    b    = model_regs[inst[24:20]];
    sum  = a + imm;
    exp_itype     = ITYPE_ILLEGAL;
    exp_rs1_ren   = 1'b0;
    exp_rs2_ren   = 1'b0;
    exp_memren    = 1'b0;
    exp_memwen    = 1'b0;
    exp_op1       = '0;
    exp_op2       = '0;
    exp_t1        = '0;
    exp_memaddr   = '0;
    exp_memwdata  = '0;
    exp_csr_op    = CSR_NONE;
    exp_csr_wdata = '0;
    case (inst[6:0])
      OPC_OP, OPC_BRANCH: begin
        exp_itype   = (inst[6:0] == OPC_OP) ? ITYPE_R : ITYPE_B;
        exp_rs1_ren = 1'b1;
        exp_rs2_ren = 1'b1;
        exp_op1     = a;
        exp_op2     = b;
        exp_t1      = (inst[6:0] == OPC_BRANCH) ? pc + imm : '0;
      end
      OPC_IMM, OPC_LOAD: begin
        exp_itype   = ITYPE_I;
        exp_rs1_ren = 1'b1;
        exp_op1     = a;
        exp_op2     = imm;
        exp_memren  = (inst[6:0] == OPC_LOAD);
        exp_memaddr = exp_memren ? sum : '0;
      end
      OPC_STORE: begin
        exp_itype    = ITYPE_S;
        exp_rs1_ren  = 1'b1;
        exp_rs2_ren  = 1'b1;
        exp_op1      = a;
        exp_op2      = imm;
        exp_memwen   = 1'b1;
        exp_memaddr  = sum;
        exp_memwdata = b;
      end
      OPC_LUI, OPC_AUIPC: begin
        exp_itype = ITYPE_U;
        exp_op1   = (inst[6:0] == OPC_AUIPC) ? pc : '0;
        exp_op2   = imm;
      end
      OPC_JAL, OPC_JALR: begin
        exp_itype   = (inst[6:0] == OPC_JAL) ? ITYPE_J : ITYPE_I;
        exp_rs1_ren = (inst[6:0] == OPC_JALR);
        exp_op1     = pc;
        exp_op2     = 64'd4;
        exp_t1      = (inst[6:0] == OPC_JAL) ? pc + imm : {sum[63:1], 1'b0};
      end
      OPC_SYSTEM: begin
        exp_itype   = ITYPE_CSR;
        exp_rs1_ren = !inst[14];
        src         = inst[14] ? xlen_t'(inst[19:15]) : a;
        case (inst[31:20])
          `CSR_MSCRATCH: exp_op1 = model_mscratch;
          `CSR_MINSTRET: exp_op1 = xlen_t'(idx);
          `CSR_MCYCLE: begin
            bit_eq("mcycle strictly increasing", o_op1 > last_mcycle, 1'b1);
            last_mcycle = o_op1;
            exp_op1     = cycle_count;
          end
          default: exp_op1 = '0;
        endcase
        case (inst[13:12])
          2'b01: begin
            exp_csr_op    = CSR_WRITE;
            exp_csr_wdata = src;
          end
          2'b10: begin
            exp_csr_op    = CSR_SET;
            exp_csr_wdata = exp_op1 | src;
          end
          default: begin
            exp_csr_op    = CSR_CLEAR;
            exp_csr_wdata = exp_op1 & ~src;
          end
        endcase
      end
      default: begin
      end
    endcase
  endtask

  task automatic compare_outputs(input int idx);
    inst_t inst;
    inst = row_inst[idx];
    word_eq("o_inst", xlen_t'(o_inst), xlen_t'(inst));
    word_eq("o_pc", o_pc, row_pc[idx]);
    word_eq("o_pc_pred", o_pc_pred, row_pc[idx] + 64'd4);
    word_eq("o_opcode", xlen_t'(o_opcode), xlen_t'(inst[6:0]));
    word_eq("o_funct3", xlen_t'(o_funct3), xlen_t'(inst[14:12]));
    word_eq("o_funct7", xlen_t'(o_funct7), xlen_t'(inst[31:25]));
    index_eq("o_rs1", o_rs1, inst[19:15]);
    index_eq("o_rs2", o_rs2, inst[24:20]);
    index_eq("o_rd", o_rd, inst[11:7]);
    itype_eq("o_itype", o_itype, exp_itype);
    bit_eq("o_rs1_ren", o_rs1_ren, exp_rs1_ren);
    bit_eq("o_rs2_ren", o_rs2_ren, exp_rs2_ren);
    bit_eq("o_memren", o_memren, exp_memren);
    bit_eq("o_memwen", o_memwen, exp_memwen);
    word_eq("o_op1", o_op1, exp_op1);
    word_eq("o_op2", o_op2, exp_op2);
    word_eq("o_t1", o_t1, exp_t1);
    word_eq("o_memaddr", o_memaddr, exp_memaddr);
    word_eq("o_memwdata", o_memwdata, exp_memwdata);
    word_eq("o_csr_addr", xlen_t'(o_csr_addr), xlen_t'(inst[31:20]));
    csr_op_eq("o_csr_op", o_csr_op, exp_csr_op);
    word_eq("o_csr_wdata", o_csr_wdata, exp_csr_wdata);
  endtask

  task automatic apply_row(input int idx);
    int h;
    @(posedge clk);
    i_fetched_req <= 1'b1;
    i_inst        <= row_inst[idx];
    i_pc          <= row_pc[idx];
    i_pc_pred     <= row_pc[idx] + 64'd4;
    wait_fetch_ack();
    @(posedge clk);
    // the stage must ignore the fetch inputs once it holds the row.
    i_fetched_req <= 1'b0;
    i_inst        <= ~row_inst[idx];
    i_pc          <= ~row_pc[idx];
    i_pc_pred     <= ~(row_pc[idx] + 64'd4);
    wait_decode_req();
    predict_row(idx);
    compare_outputs(idx);
    bit_eq("o_fetched_ack while full", o_fetched_ack, 1'b0);
    // everything holds under back-pressure.
    for (h = 0; h < row_hold[idx]; h++) begin
      @(negedge clk);
      bit_eq("o_decoded_req under back-pressure", o_decoded_req, 1'b1);
      bit_eq("o_fetched_ack under back-pressure", o_fetched_ack, 1'b0);
      compare_outputs(idx);
    end
    @(posedge clk);
    i_decoded_ack <= 1'b1;
    @(negedge clk);
    bit_eq("o_fetched_ack with i_decoded_ack high", o_fetched_ack, 1'b1);
    @(posedge clk);
    i_decoded_ack <= 1'b0;
    @(negedge clk);
    bit_eq("o_decoded_req after transfer", o_decoded_req, 1'b0);
  endtask

  task automatic write_registers();
    xlen_t data;
    for (int r = 0; r < `NUM_REGS; r++) begin
      data = random_word();
      @(posedge clk);
      i_wb_en   <= 1'b1;
      i_wb_rd   <= reg_addr_t'(r);
      i_wb_data <= data;
      // x0 drops the write.
      if (r != 0) begin
        model_regs[r] = data;
      end
    end
    data = random_word();
    @(posedge clk);
    i_wb_en     <= 1'b0;
    i_csr_wen   <= 1'b1;
    i_csr_waddr <= `CSR_MSCRATCH;
    i_csr_wdata <= data;
    model_mscratch = data;
    @(posedge clk);
    // minstret is read-only and drops this write.
    i_csr_waddr <= `CSR_MINSTRET;
    i_csr_wdata <= random_word();
    @(posedge clk);
    i_csr_wen <= 1'b0;
  endtask

  initial begin
    rst            = 1'b1;
    i_fetched_req  = 1'b0;
    i_decoded_ack  = 1'b0;
    i_pc           = '0;
    i_pc_pred      = '0;
    i_inst         = '0;
    i_wb_en        = 1'b0;
    i_wb_rd        = '0;
    i_wb_data      = '0;
    i_csr_wen      = 1'b0;
    i_csr_waddr    = '0;
    i_csr_wdata    = '0;
    lfsr_state     = 32'd81318;
    last_mcycle    = '0;
    model_mscratch = '0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    bit_eq("o_decoded_req after reset", o_decoded_req, 1'b0);
    bit_eq("o_fetched_ack after reset", o_fetched_ack, 1'b1);
    // first row sees the cleared register file.
    apply_row(0);
    write_registers();
    for (int i = 1; i < row_inst.size(); i++) begin
      apply_row(i);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: decode_top.sv
////////////////////////////////////////////////////////////////////////////
// Decode subsystem top: stage, register file, CSR file and counters.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module decode_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_fetched_req,
  output logic                       o_fetched_ack,
  input  wire  decode_pkg::xlen_t    i_pc,
  input  wire  decode_pkg::inst_t    i_inst,
  input  wire  decode_pkg::xlen_t    i_pc_pred,
  output logic                       o_decoded_req,
  input  wire                        i_decoded_ack,
  output decode_pkg::xlen_t          o_pc,
  output decode_pkg::xlen_t          o_pc_pred,
  output decode_pkg::inst_t          o_inst,
  output decode_pkg::reg_addr_t      o_rs1,
  output decode_pkg::reg_addr_t      o_rs2,
  output decode_pkg::reg_addr_t      o_rd,
  output logic                       o_rs1_ren,
  output logic                       o_rs2_ren,
  output decode_pkg::itype_e         o_itype,
  output logic [6:0]                 o_opcode,
  output logic [2:0]                 o_funct3,
  output logic [6:0]                 o_funct7,
  output decode_pkg::xlen_t          o_op1,
  output decode_pkg::xlen_t          o_op2,
  output decode_pkg::xlen_t          o_t1,
  output logic                       o_memren,
  output logic                       o_memwen,
  output decode_pkg::xlen_t          o_memaddr,
  output decode_pkg::xlen_t          o_memwdata,
  output decode_pkg::csr_addr_t      o_csr_addr,
  output decode_pkg::csr_op_e        o_csr_op,
  output decode_pkg::xlen_t          o_csr_wdata,
  input  wire                        i_wb_en,
  input  wire  decode_pkg::reg_addr_t i_wb_rd,
  input  wire  decode_pkg::xlen_t    i_wb_data,
  input  wire                        i_csr_wen,
  input  wire  decode_pkg::csr_addr_t i_csr_waddr,
  input  wire  decode_pkg::xlen_t    i_csr_wdata
);

  import decode_pkg::*;

  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t csr_rdata;
  xlen_t mcycle;
  xlen_t minstret;
  logic  decoded_fire;

  id_stage u_id_stage (
    .clk            (clk),
    .rst            (rst),
    .i_fetched_req  (i_fetched_req),
    .o_fetched_ack  (o_fetched_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .i_pc_pred      (i_pc_pred),
    .o_decoded_req  (o_decoded_req),
    .i_decoded_ack  (i_decoded_ack),
    .o_pc           (o_pc),
    .o_pc_pred      (o_pc_pred),
    .o_inst         (o_inst),
    .o_rs1          (o_rs1),
    .o_rs2          (o_rs2),
    .o_rd           (o_rd),
    .o_rs1_ren      (o_rs1_ren),
    .o_rs2_ren      (o_rs2_ren),
    .o_itype        (o_itype),
    .o_opcode       (o_opcode),
    .o_funct3       (o_funct3),
    .o_funct7       (o_funct7),
    .o_op1          (o_op1),
    .o_op2          (o_op2),
    .o_t1           (o_t1),
    .o_memren       (o_memren),
    .o_memwen       (o_memwen),
    .o_memaddr      (o_memaddr),
    .o_memwdata     (o_memwdata),
    .o_csr_addr     (o_csr_addr),
    .o_csr_op       (o_csr_op),
    .o_csr_wdata    (o_csr_wdata),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .i_csr_rdata    (csr_rdata),
    .o_decoded_fire (decoded_fire)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (o_rs1),
    .i_rs2      (o_rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wb_en    (i_wb_en),
    .i_wb_rd    (i_wb_rd),
    .i_wb_data  (i_wb_data)
  );

  csr_file u_csr_file (
    .clk        (clk),
    .rst        (rst),
    .i_raddr    (o_csr_addr),
    .o_rdata    (csr_rdata),
    .i_wen      (i_csr_wen),
    .i_waddr    (i_csr_waddr),
    .i_wdata    (i_csr_wdata),
    .i_mcycle   (mcycle),
    .i_minstret (minstret)
  );

  inst_counter u_inst_counter (
    .clk        (clk),
    .rst        (rst),
    .i_retire   (decoded_fire),
    .o_mcycle   (mcycle),
    .o_minstret (minstret)
  );

endmodule

`default_nettype wire

// File: inst_counter.sv
////////////////////////////////////////////////////////////////////////////
// Cycle and retired-instruction counters.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module inst_counter (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_retire,
  output decode_pkg::xlen_t       o_mcycle,
  output decode_pkg::xlen_t       o_minstret
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mcycle <= '0;
    end else begin
      o_mcycle <= o_mcycle + 1'b1;
    end
  end

  // one count per decoded transfer.
  always_ff @(posedge clk) begin
    if (rst) begin
      o_minstret <= '0;
    end else if (i_retire) begin
      o_minstret <= o_minstret + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: csr_file.sv
////////////////////////////////////////////////////////////////////////////
// Machine CSR file: mtvec, mscratch, mepc storage and read-only counters.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "decode_macros.svh"

module csr_file (
  input  wire                        clk,
  input  wire                        rst,
  input  wire  decode_pkg::csr_addr_t i_raddr,
  output decode_pkg::xlen_t          o_rdata,
  input  wire                        i_wen,
  input  wire  decode_pkg::csr_addr_t i_waddr,
  input  wire  decode_pkg::xlen_t    i_wdata,
  input  wire  decode_pkg::xlen_t    i_mcycle,
  input  wire  decode_pkg::xlen_t    i_minstret
);

  import decode_pkg::*;

  xlen_t mtvec_q;
  xlen_t mscratch_q;
  xlen_t mepc_q;

  // counters and unknown addresses drop writes.
  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else if (i_wen) begin
      case (i_waddr)
        `CSR_MTVEC:    mtvec_q    <= i_wdata;
        `CSR_MSCRATCH: mscratch_q <= i_wdata;
        `CSR_MEPC:     mepc_q     <= i_wdata;
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      `CSR_MTVEC:    o_rdata = mtvec_q;
      `CSR_MSCRATCH: o_rdata = mscratch_q;
      `CSR_MEPC:     o_rdata = mepc_q;
      `CSR_MCYCLE:   o_rdata = i_mcycle;
      `CSR_MINSTRET: o_rdata = i_minstret;
      default:       o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: regfile.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file, two async reads, one sync write, x0 hardwired.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "decode_macros.svh"

module regfile (
  input  wire                        clk,
  input  wire                        rst,
  input  wire  decode_pkg::reg_addr_t i_rs1,
  input  wire  decode_pkg::reg_addr_t i_rs2,
  output decode_pkg::xlen_t          o_rs1_data,
  output decode_pkg::xlen_t          o_rs2_data,
  input  wire                        i_wb_en,
  input  wire  decode_pkg::reg_addr_t i_wb_rd,
  input  wire  decode_pkg::xlen_t    i_wb_data
);

  import decode_pkg::*;

  xlen_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_en && (i_wb_rd != '0)) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // x0 always reads zero.
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: id_stage.sv
////////////////////////////////////////////////////////////////////////////
// Decode stage: one-entry instruction holding register with fetch and
// execute req/ack handshakes, feeding the combinational decoder.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module id_stage (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_fetched_req,
  output logic                       o_fetched_ack,
  input  wire  decode_pkg::xlen_t    i_pc,
  input  wire  decode_pkg::inst_t    i_inst,
  input  wire  decode_pkg::xlen_t    i_pc_pred,
  output logic                       o_decoded_req,
  input  wire                        i_decoded_ack,
  output decode_pkg::xlen_t          o_pc,
  output decode_pkg::xlen_t          o_pc_pred,
  output decode_pkg::inst_t          o_inst,
  output decode_pkg::reg_addr_t      o_rs1,
  output decode_pkg::reg_addr_t      o_rs2,
  output decode_pkg::reg_addr_t      o_rd,
  output logic                       o_rs1_ren,
  output logic                       o_rs2_ren,
  output decode_pkg::itype_e         o_itype,
  output logic [6:0]                 o_opcode,
  output logic [2:0]                 o_funct3,
  output logic [6:0]                 o_funct7,
  output decode_pkg::xlen_t          o_op1,
  output decode_pkg::xlen_t          o_op2,
  output decode_pkg::xlen_t          o_t1,
  output logic                       o_memren,
  output logic                       o_memwen,
  output decode_pkg::xlen_t          o_memaddr,
  output decode_pkg::xlen_t          o_memwdata,
  output decode_pkg::csr_addr_t      o_csr_addr,
  output decode_pkg::csr_op_e        o_csr_op,
  output decode_pkg::xlen_t          o_csr_wdata,
  input  wire  decode_pkg::xlen_t    i_rs1_data,
  input  wire  decode_pkg::xlen_t    i_rs2_data,
  input  wire  decode_pkg::xlen_t    i_csr_rdata,
  output logic                       o_decoded_fire
);

  import decode_pkg::*;

  id_state_e state_q;
  inst_t     inst_q;
  xlen_t     pc_q;
  xlen_t     pc_pred_q;
  logic      fetched_fire;

  // a full stage accepts a new instruction in the cycle it hands one off.
  assign o_decoded_req  = (state_q == ST_FULL);
  assign o_fetched_ack  = (state_q == ST_EMPTY) || i_decoded_ack;
  assign fetched_fire   = i_fetched_req && o_fetched_ack;
  assign o_decoded_fire = o_decoded_req && i_decoded_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_EMPTY;
    end else if (fetched_fire) begin
      state_q <= ST_FULL;
    end else if (o_decoded_fire) begin
      state_q <= ST_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (fetched_fire) begin
      inst_q    <= i_inst;
      pc_q      <= i_pc;
      pc_pred_q <= i_pc_pred;
    end
  end

  assign o_inst    = inst_q;
  assign o_pc      = pc_q;
  assign o_pc_pred = pc_pred_q;

  id_decoder u_id_decoder (
    .i_inst      (inst_q),
    .i_pc        (pc_q),
    .i_rs1_data  (i_rs1_data),
    .i_rs2_data  (i_rs2_data),
    .i_csr_rdata (i_csr_rdata),
    .o_rs1       (o_rs1),
    .o_rs2       (o_rs2),
    .o_rd        (o_rd),
    .o_rs1_ren   (o_rs1_ren),
    .o_rs2_ren   (o_rs2_ren),
    .o_itype     (o_itype),
    .o_opcode    (o_opcode),
    .o_funct3    (o_funct3),
    .o_funct7    (o_funct7),
    .o_op1       (o_op1),
    .o_op2       (o_op2),
    .o_t1        (o_t1),
    .o_memren    (o_memren),
    .o_memwen    (o_memwen),
    .o_memaddr   (o_memaddr),
    .o_memwdata  (o_memwdata),
    .o_csr_addr  (o_csr_addr),
    .o_csr_op    (o_csr_op),
    .o_csr_wdata (o_csr_wdata)
  );

endmodule

`default_nettype wire

// File: id_decoder.sv
////////////////////////////////////////////////////////////////////////////
// RV64I decoder: field extraction, immediates, operand and CSR data select.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module id_decoder (
  input  wire  decode_pkg::inst_t    i_inst,
  input  wire  decode_pkg::xlen_t    i_pc,
  input  wire  decode_pkg::xlen_t    i_rs1_data,
  input  wire  decode_pkg::xlen_t    i_rs2_data,
  input  wire  decode_pkg::xlen_t    i_csr_rdata,
  output decode_pkg::reg_addr_t      o_rs1,
  output decode_pkg::reg_addr_t      o_rs2,
  output decode_pkg::reg_addr_t      o_rd,
  output logic                       o_rs1_ren,
  output logic                       o_rs2_ren,
  output decode_pkg::itype_e         o_itype,
  output logic [6:0]                 o_opcode,
  output logic [2:0]                 o_funct3,
  output logic [6:0]                 o_funct7,
  output decode_pkg::xlen_t          o_op1,
  output decode_pkg::xlen_t          o_op2,
  output decode_pkg::xlen_t          o_t1,
  output logic                       o_memren,
  output logic                       o_memwen,
  output decode_pkg::xlen_t          o_memaddr,
  output decode_pkg::xlen_t          o_memwdata,
  output decode_pkg::csr_addr_t      o_csr_addr,
  output decode_pkg::csr_op_e        o_csr_op,
  output decode_pkg::xlen_t          o_csr_wdata
);

  import decode_pkg::*;

  localparam logic [6:0] OPC_LUI        = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC      = 7'b0010111;
  localparam logic [6:0] OPC_JAL        = 7'b1101111;
  localparam logic [6:0] OPC_JALR       = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH     = 7'b1100011;
  localparam logic [6:0] OPC_LOAD       = 7'b0000011;
  localparam logic [6:0] OPC_STORE      = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM     = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32  = 7'b0011011;
  localparam logic [6:0] OPC_OP         = 7'b0110011;
  localparam logic [6:0] OPC_OP_32      = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM     = 7'b1110011;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  xlen_t csr_src;

  assign o_opcode   = i_inst[6:0];
  assign o_rd       = i_inst[11:7];
  assign o_funct3   = i_inst[14:12];
  assign o_rs1      = i_inst[19:15];
  assign o_rs2      = i_inst[24:20];
  assign o_funct7   = i_inst[31:25];
  assign o_csr_addr = i_inst[31:20];

  // sign-extended immediates.
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_itype    = ITYPE_ILLEGAL;
    o_rs1_ren  = 1'b0;
    o_rs2_ren  = 1'b0;
    o_memren   = 1'b0;
    o_memwen   = 1'b0;
    o_op1      = '0;
    o_op2      = '0;
    o_t1       = '0;
    o_memaddr  = '0;
    o_memwdata = '0;
    o_csr_op   = CSR_NONE;
    case (o_opcode)
      OPC_OP, OPC_OP_32: begin
        o_itype   = ITYPE_R;
        o_rs1_ren = 1'b1;
        o_rs2_ren = 1'b1;
        o_op1     = i_rs1_data;
        o_op2     = i_rs2_data;
      end
      OPC_OP_IMM, OPC_OP_IMM_32, OPC_LOAD: begin
        o_itype   = ITYPE_I;
        o_rs1_ren = 1'b1;
        o_op1     = i_rs1_data;
        o_op2     = imm_i;
        if (o_opcode == OPC_LOAD) begin
          o_memren  = 1'b1;
          o_memaddr = i_rs1_data + imm_i;
        end
      end
      OPC_STORE: begin
        o_itype    = ITYPE_S;
        o_rs1_ren  = 1'b1;
        o_rs2_ren  = 1'b1;
        o_op1      = i_rs1_data;
        o_op2      = imm_s;
        o_memwen   = 1'b1;
        o_memaddr  = i_rs1_data + imm_s;
        o_memwdata = i_rs2_data;
      end
      OPC_BRANCH: begin
        o_itype   = ITYPE_B;
        o_rs1_ren = 1'b1;
        o_rs2_ren = 1'b1;
        o_op1     = i_rs1_data;
        o_op2     = i_rs2_data;
        o_t1      = i_pc + imm_b;
      end
      OPC_LUI, OPC_AUIPC: begin
        o_itype = ITYPE_U;
        o_op1   = (o_opcode == OPC_AUIPC) ? i_pc : '0;
        o_op2   = imm_u;
      end
      OPC_JAL: begin
        o_itype = ITYPE_J;
        o_op1   = i_pc;
        o_op2   = xlen_t'(4);
        o_t1    = i_pc + imm_j;
      end
      OPC_JALR: begin
        o_itype   = ITYPE_I;
        o_rs1_ren = 1'b1;
        o_op1     = i_pc;
        o_op2     = xlen_t'(4);
        o_t1      = (i_rs1_data + imm_i) & ~xlen_t'(1);
      end
      OPC_SYSTEM: begin
        // ecall and ebreak stay illegal here.
        if (o_funct3[1:0] != 2'b00) begin
          o_itype   = ITYPE_CSR;
          o_rs1_ren = !o_funct3[2];
          o_op1     = i_csr_rdata;
          o_csr_op  = csr_op_e'(o_funct3[1:0]);
        end
      end
      default: begin
      end
    endcase
  end

  // funct3[2] selects the 5-bit immediate form.
  assign csr_src = o_funct3[2] ? xlen_t'(o_rs1) : i_rs1_data;

  always_comb begin
    case (o_csr_op)
      CSR_WRITE: o_csr_wdata = csr_src;
      CSR_SET:   o_csr_wdata = i_csr_rdata | csr_src;
      CSR_CLEAR: o_csr_wdata = i_csr_rdata & ~csr_src;
      default:   o_csr_wdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: decode_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Decode package: vector types and enums shared by the decode subsystem.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`INST_W-1:0]     inst_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  // instruction class.
  typedef enum logic [2:0] {
    ITYPE_R,
    ITYPE_I,
    ITYPE_S,
    ITYPE_B,
    ITYPE_U,
    ITYPE_J,
    ITYPE_CSR,
    ITYPE_ILLEGAL
  } itype_e;

  // encoding matches funct3[1:0] of the csr instructions.
  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_e;

  typedef enum logic {
    ST_EMPTY,
    ST_FULL
  } id_state_e;

endpackage

`default_nettype wire

// File: decode_macros.svh
////////////////////////////////////////////////////////////////////////////
// Decode subsystem constants: data, instruction, register and CSR widths,
// plus the machine CSR addresses.
////////////////////////////////////////////////////////////////////////////

`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath widths.
`define XLEN         64
`define INST_W       32
`define REG_ADDR_W   5
`define NUM_REGS     32
`define CSR_ADDR_W   12

// machine CSR addresses.
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02

`endif
